//--- flist.f
+incdir+common
+incdir+verif
common/x68_ctrl_pkg.sv
common/x68_media_pkg.sv
common/clk_en_if.sv
src/clk_enable_gen.sv
src/reset_sequencer.sv
src/loader_bridge.sv
src/audio_compressor.sv
src/activity_led.sv
src/x68_guest_top.sv
verif/tb_x68_guest_top.sv

//--- verif/tb_checks.svh
// Testbench checks
// comparison task, error counters and reference models for the
// compressor curve and the enable periods

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int chk_cnt = 0;
int err_cnt = 0;
int err_mark = 0;

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("mismatch %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic note_failure(input string msg);
	err_cnt++;
	$display("error: %s", msg);
endtask

// measured lengths may be off by a small tolerance
task automatic check_near(input string name, input int got, input int exp, input int tol);
	int adj;
	adj = (got >= exp - tol && got <= exp + tol) ? exp : got;
	check(name, adj, exp);
endtask

task automatic finish_test(input string name);
	$display("test %s done, %0d errors", name, err_cnt - err_mark);
	err_mark = err_cnt;
endtask

// expected compressor output for one sample
function automatic logic [15:0] compress_ref(input logic [15:0] s, input logic sel);
	int mag;
	int knee;
	int gain;
	int flat;
	int base;
	int r;
	mag = s[15] ? 65536 - int'(s) : int'(s);
	knee = sel ? `CMP_X2 : `CMP_X1;
	gain = sel ? `CMP_A2 : `CMP_A1;
	flat = sel ? `CMP_F2 : `CMP_F1;
	base = sel ? `CMP_B2 : `CMP_B1;
	r = (mag < knee) ? mag * gain : (mag - knee) / flat + base;
	r = r & 32'hffff;
	// negative input gives the negated result
	if (s[15])
		r = (65536 - r) & 32'hffff;
	return r[15:0];
endfunction

// enable index runs from sys_ce_o at 0 up to opm_ce_o[1] at 5
function automatic int ce_period(input int idx, input bit turbo, input bit mode);
	case (idx)
		0: return 4;
		1, 2: return turbo ? 2 : 4;
		3: return mode ? `SND2_DIV : `SND_DIV;
		4: return `SND2_DIV;
		default: return `OPM_DIV;
	endcase
endfunction

`endif

//--- verif/tb_x68_guest_top.sv
// X68000 guest glue testbench
// drives the glue top through clock enables, loader, core reset,
// mount and eject, compressor and LED tests against reference models

`include "x68_glue_params.svh"

module tb_x68_guest_top;
	import x68_ctrl_pkg::*;
	import x68_media_pkg::*;

	// six test lengths plus margin
	localparam int TEST_CYCLES = 4 * 215 + 20 * 12 + `HDD_RESET_HOLD + `MOUNT_HOLD / 4
		+ `EJECT_HOLD + 2 * 100 + `LED_HOLD + 400;
	localparam int CYCLE_LIMIT = TEST_CYCLES + 12000;

	logic         clk_sys;
	logic         reset_delayed;
	logic         turbo_i;
	logic         clock_mode_i;
	status_word_t status_w;
	logic [1:0]   buttons_i;
	logic         pll_locked_i;
	drive_vec_t   img_mounted_i;
	logic         ioctl_download_i;
	logic         ioctl_wr_i;
	ldr_addr_t    ioctl_addr_i;
	ldr_data_t    ioctl_dout_i;
	logic         ldr_ack_i;
	logic [3:0]   sd_ack_i;
	sample_t      aud_l_i;
	sample_t      aud_r_i;
	logic         sys_ce_o;
	logic         mpu_cep_o;
	logic         mpu_cen_o;
	logic         snd_ce_o;
	opm_ce_t      opm_ce_o;
	logic         core_rstn_o;
	drive_vec_t   mounted_d_o;
	fdd_vec_t     eject_d_o;
	ldr_addr_t    ldr_addr_o;
	ldr_data_t    ldr_wdat_o;
	logic         ldr_aen_o;
	logic         ldr_wr_o;
	logic         ldr_done_o;
	sample_t      aud_l_o;
	sample_t      aud_r_o;
	logic         fdd_led_o;
	logic         hdd_led_o;

	integer       seed = 32'hcfdf_2e11;
	int           cycle_cnt = 0;
	logic         ce_active = 1'b0;
	logic         cmp_active = 1'b0;
	int           ce_last [6];
	int           ce_cnt [6];
	logic [5:0]   ce_vec;
	logic [1:0]   cmp_v = '0;
	logic [15:0]  cmp_exp_l [2];
	logic [15:0]  cmp_exp_r [2];
	string        ce_names [6] = '{"sys_ce_o", "mpu_cep_o", "mpu_cen_o", "snd_ce_o",
		"opm_ce_o[0]", "opm_ce_o[1]"};

	`include "tb_checks.svh"

	assign ce_vec = {opm_ce_o, snd_ce_o, mpu_cen_o, mpu_cep_o, sys_ce_o};

	x68_guest_top u_x68_guest_top (
		.clk_sys          (clk_sys),
		.reset_delayed    (reset_delayed),
		.turbo_i          (turbo_i),
		.clock_mode_i     (clock_mode_i),
		.status_i         (status_w.raw),
		.buttons_i        (buttons_i),
		.pll_locked_i     (pll_locked_i),
		.img_mounted_i    (img_mounted_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ldr_ack_i        (ldr_ack_i),
		.sd_ack_i         (sd_ack_i),
		.aud_l_i          (aud_l_i),
		.aud_r_i          (aud_r_i),
		.sys_ce_o         (sys_ce_o),
		.mpu_cep_o        (mpu_cep_o),
		.mpu_cen_o        (mpu_cen_o),
		.snd_ce_o         (snd_ce_o),
		.opm_ce_o         (opm_ce_o),
		.core_rstn_o      (core_rstn_o),
		.mounted_d_o      (mounted_d_o),
		.eject_d_o        (eject_d_o),
		.ldr_addr_o       (ldr_addr_o),
		.ldr_wdat_o       (ldr_wdat_o),
		.ldr_aen_o        (ldr_aen_o),
		.ldr_wr_o         (ldr_wr_o),
		.ldr_done_o       (ldr_done_o),
		.aud_l_o          (aud_l_o),
		.aud_r_o          (aud_r_o),
		.fdd_led_o        (fdd_led_o),
		.hdd_led_o        (hdd_led_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// inputs change and outputs are sampled 10 units after the edge
	task automatic step();
		@(posedge clk_sys);
		#10;
	endtask

	function automatic logic probe(input int sel);
		return sel ? mounted_d_o[0] : core_rstn_o;
	endfunction

	task automatic count_until(input int sel, input logic level, input int limit,
		output int n);
		n = 0;
		while (probe(sel) !== level && n < limit) begin
			step();
			n++;
		end
		if (probe(sel) !== level)
			note_failure($sformatf("%s did not go to %0b within %0d cycles",
				sel ? "mounted_d_o[0]" : "core_rstn_o", level, limit));
	endtask

	////////////////////////////////////////
	// comparison process
	////////////////////////////////////////

	always @(negedge clk_sys) begin
		cycle_cnt++;
		if (ce_active) begin
			if (mpu_cep_o && mpu_cen_o)
				note_failure("mpu_cep_o and mpu_cen_o high in the same cycle");
			for (int i = 0; i < 6; i++) begin
				if (ce_vec[i]) begin
					if (ce_last[i] >= 0)
						check({ce_names[i], " spacing"}, cycle_cnt - ce_last[i],
							ce_period(i, turbo_i, clock_mode_i));
					// cen sits half a period after cep
					if (i == 2 && ce_last[1] >= 0)
						check("mpu_cen_o phase", cycle_cnt - ce_last[1],
							ce_period(1, turbo_i, clock_mode_i) / 2);
					ce_last[i] = cycle_cnt;
					ce_cnt[i]++;
				end
			end
		end
		// compressor output trails its input by two cycles
		if (cmp_v[1]) begin
			check("aud_l_o", aud_l_o, cmp_exp_l[1]);
			check("aud_r_o", aud_r_o, cmp_exp_r[1]);
		end
		cmp_v[1] = cmp_v[0];
		cmp_exp_l[1] = cmp_exp_l[0];
		cmp_exp_r[1] = cmp_exp_r[0];
		cmp_v[0] = cmp_active;
		cmp_exp_l[0] = compress_ref(aud_l_i, status_w.f.curve_sel);
		cmp_exp_r[0] = compress_ref(aud_r_i, status_w.f.curve_sel);
	end

	initial begin
		wait (cycle_cnt >= CYCLE_LIMIT);
		$display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
		$display("Simulation FAILED");
		$finish;
	end

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic measure_enables(input bit turbo, input bit mode);
		turbo_i = turbo;
		clock_mode_i = mode;
		// let turbo reach the next bus cycle
		repeat (12) step();
		for (int i = 0; i < 6; i++) begin
			ce_last[i] = -1;
			ce_cnt[i] = 0;
		end
		ce_active = 1'b1;
		repeat (200) step();
		ce_active = 1'b0;
		for (int i = 0; i < 6; i++)
			check({ce_names[i], " count"}, ce_cnt[i], 200 / ce_period(i, turbo, mode));
	endtask

	task automatic stream_loader_writes();
		ldr_addr_t a;
		ldr_data_t d;
		int        dly;
		ioctl_download_i = 1'b1;
		step();
		for (int n = 0; n < 20; n++) begin
			a = 20'($random(seed));
			d = 8'($random(seed));
			dly = $random(seed) & 7;
			ioctl_wr_i = 1'b1;
			ioctl_addr_i = a;
			ioctl_dout_i = d;
			step();
			ioctl_wr_i = 1'b0;
			check("ldr_wr_o", ldr_wr_o, 1);
			check("ldr_addr_o", ldr_addr_o, a);
			check("ldr_wdat_o", ldr_wdat_o, d);
			check("ldr_aen_o", ldr_aen_o, 1);
			repeat (dly) begin
				step();
				check("ldr_wr_o", ldr_wr_o, 1);
			end
			ldr_ack_i = 1'b1;
			step();
			check("ldr_wr_o", ldr_wr_o, 0);
			ldr_ack_i = 1'b0;
			step();
		end
		ioctl_download_i = 1'b0;
		step();
		check("ldr_done_o", ldr_done_o, 1);
		check("ldr_aen_o", ldr_aen_o, 0);
		// writes after the download are dropped
		ioctl_wr_i = 1'b1;
		ioctl_addr_i = ~a;
		step();
		ioctl_wr_i = 1'b0;
		step();
		check("ldr_wr_o", ldr_wr_o, 0);
		check("ldr_addr_o", ldr_addr_o, a);
	endtask

	task automatic cycle_core_reset();
		int n;
		check("core_rstn_o", core_rstn_o, 0);
		status_w.f.reset = 1'b0;
		count_until(0, 1'b1, 10, n);
		img_mounted_i = 4'b0100;
		step();
		img_mounted_i = 4'b0000;
		count_until(0, 1'b0, 10, n);
		// the hard disk slot has no eject window
		check("mounted_d_o[2]", mounted_d_o[2], 1);
		count_until(0, 1'b1, `HDD_RESET_HOLD + 20, n);
		check_near("core_rstn_o low cycles", n, `HDD_RESET_HOLD, 2);
	endtask

	task automatic mount_and_eject();
		int n;
		img_mounted_i = 4'b0001;
		step();
		img_mounted_i = 4'b0000;
		check("mounted_d_o[0]", mounted_d_o[0], 0);
		count_until(1, 1'b1, `MOUNT_HOLD / 4 + 20, n);
		check_near("mounted_d_o[0] delay", n, `MOUNT_HOLD / 4, 2);
		check("eject_d_o[0]", eject_d_o[0], 0);
		status_w.f.fd_eject = 2'b01;
		step();
		status_w.f.fd_eject = 2'b00;
		count_until(1, 1'b0, 10, n);
		check("eject_d_o[0]", eject_d_o[0], 1);
		count_until(1, 1'b1, `EJECT_HOLD + 20, n);
		check_near("mounted_d_o[0] mask cycles", n, `EJECT_HOLD, 2);
	endtask

	task automatic sweep_compressor();
		for (int c = 0; c < 2; c++) begin
			status_w.f.curve_sel = c[0];
			cmp_active = 1'b1;
			for (int n = 0; n < 100; n++) begin
				// full scale on both sides first
				if (n == 0) begin
					aud_l_i = 16'h8000;
					aud_r_i = 16'h7fff;
				end else begin
					aud_l_i = 16'($random(seed));
					aud_r_i = 16'($random(seed));
				end
				step();
			end
		end
		cmp_active = 1'b0;
		aud_l_i = '0;
		aud_r_i = '0;
		repeat (3) step();
	endtask

	task automatic pulse_leds();
		int nf;
		int nh;
		repeat (3) begin
			repeat (40) step();
			sd_ack_i = 4'b0101;
			step();
			sd_ack_i = 4'b0000;
		end
		nf = 0;
		nh = 0;
		repeat (`LED_HOLD + 10) begin
			nf += fdd_led_o;
			nh += hdd_led_o;
			step();
		end
		check_near("fdd_led_o on cycles", nf, `LED_HOLD, 2);
		check_near("hdd_led_o on cycles", nh, `LED_HOLD, 2);
		check("leds at end", {fdd_led_o, hdd_led_o}, 0);
	endtask

	initial begin
		reset_delayed = 1'b1;
		turbo_i = 1'b0;
		clock_mode_i = 1'b0;
		status_w.raw = '0;
		status_w.f.reset = 1'b1;
		buttons_i = 2'b00;
		pll_locked_i = 1'b1;
		img_mounted_i = '0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_dout_i = '0;
		ldr_ack_i = 1'b0;
		sd_ack_i = '0;
		aud_l_i = '0;
		aud_r_i = '0;
		repeat (8) @(posedge clk_sys);
		#10;
		reset_delayed = 1'b0;
		check("outputs after reset", {sys_ce_o, mpu_cep_o, mpu_cen_o, snd_ce_o, opm_ce_o,
			ldr_wr_o, ldr_done_o, core_rstn_o, fdd_led_o, hdd_led_o}, 0);
		finish_test("reset state");
		for (int m = 0; m < 4; m++)
			measure_enables(m[1], m[0]);
		finish_test("clock enables");
		stream_loader_writes();
		finish_test("loader");
		cycle_core_reset();
		finish_test("core reset");
		mount_and_eject();
		finish_test("mount and eject");
		sweep_compressor();
		finish_test("compressor");
		pulse_leds();
		finish_test("activity leds");
		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- src/x68_guest_top.sv
// X68000 guest glue top
// clock enables, reset and media sequencing, loader bridge,
// audio compressor and drive LEDs around the X68000 core

module x68_guest_top (
	input  logic                      clk_sys,
	input  logic                      reset_delayed,
	input  logic                      turbo_i,
	input  logic                      clock_mode_i,
	input  logic [63:0]               status_i,
	input  logic [1:0]                buttons_i,
	input  logic                      pll_locked_i,
	input  x68_media_pkg::drive_vec_t img_mounted_i,
	input  logic                      ioctl_download_i,
	input  logic                      ioctl_wr_i,
	input  x68_media_pkg::ldr_addr_t  ioctl_addr_i,
	input  x68_media_pkg::ldr_data_t  ioctl_dout_i,
	input  logic                      ldr_ack_i,
	input  logic [3:0]                sd_ack_i,
	input  x68_ctrl_pkg::sample_t     aud_l_i,
	input  x68_ctrl_pkg::sample_t     aud_r_i,
	output logic                      sys_ce_o,
	output logic                      mpu_cep_o,
	output logic                      mpu_cen_o,
	output logic                      snd_ce_o,
	output x68_ctrl_pkg::opm_ce_t     opm_ce_o,
	output logic                      core_rstn_o,
	output x68_media_pkg::drive_vec_t mounted_d_o,
	output x68_media_pkg::fdd_vec_t   eject_d_o,
	output x68_media_pkg::ldr_addr_t  ldr_addr_o,
	output x68_media_pkg::ldr_data_t  ldr_wdat_o,
	output logic                      ldr_aen_o,
	output logic                      ldr_wr_o,
	output logic                      ldr_done_o,
	output x68_ctrl_pkg::sample_t     aud_l_o,
	output x68_ctrl_pkg::sample_t     aud_r_o,
	output logic                      fdd_led_o,
	output logic                      hdd_led_o
);
	import x68_ctrl_pkg::*;

	status_word_t status_w;
	logic         turbo;

	assign status_w.raw = status_i;
	// turbo from either the menu or the board pin
	assign turbo = turbo_i | status_w.f.turbo;

	////////////////////////////////////////
	// clock enables
	////////////////////////////////////////

	clk_en_if u_ce_if ();

	clk_enable_gen u_clk_enable_gen (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.turbo_i       (turbo),
		.clock_mode_i  (clock_mode_i),
		.ce            (u_ce_if.gen)
	);

	assign sys_ce_o  = u_ce_if.sys_ce;
	assign mpu_cep_o = u_ce_if.mpu_cep;
	assign mpu_cen_o = u_ce_if.mpu_cen;
	assign snd_ce_o  = u_ce_if.snd_ce;
	assign opm_ce_o  = u_ce_if.opm_ce;

	////////////////////////////////////////
	// reset, media and loader
	////////////////////////////////////////

	// buttons_i[1] is the board reset key
	reset_sequencer u_reset_sequencer (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.status_rst_i  (status_w.f.reset),
		.button_rst_i  (buttons_i[1]),
		.pll_locked_i  (pll_locked_i),
		.img_mounted_i (img_mounted_i),
		.fd_eject_i    (status_w.f.fd_eject),
		.download_i    (ioctl_download_i),
		.mounted_d_o   (mounted_d_o),
		.eject_d_o     (eject_d_o),
		.core_rstn_o   (core_rstn_o)
	);

	loader_bridge u_loader_bridge (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.download_i    (ioctl_download_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_dout_i  (ioctl_dout_i),
		.ldr_ack_i     (ldr_ack_i),
		.ldr_addr_o    (ldr_addr_o),
		.ldr_wdat_o    (ldr_wdat_o),
		.ldr_aen_o     (ldr_aen_o),
		.ldr_wr_o      (ldr_wr_o),
		.ldr_done_o    (ldr_done_o)
	);

	////////////////////////////////////////
	// audio and LEDs
	////////////////////////////////////////

	audio_compressor u_audio_compressor (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.curve_sel_i   (status_w.f.curve_sel),
		.in_l_i        (aud_l_i),
		.in_r_i        (aud_r_i),
		.out_l_o       (aud_l_o),
		.out_r_o       (aud_r_o)
	);

	activity_led u_fdd_led (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.act_i         (|sd_ack_i[1:0]),
		.led_o         (fdd_led_o)
	);

	// sram image transfers share the hard disk light
	activity_led u_hdd_led (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.act_i         (|sd_ack_i[3:2]),
		.led_o         (hdd_led_o)
	);

endmodule

//--- src/activity_led.sv
// Drive activity LED
// stretches short access pulses into a visible light

`include "x68_glue_params.svh"

module activity_led (
	input  logic clk_sys,
	input  logic reset_delayed,
	input  logic act_i,
	output logic led_o
);

	localparam int CNT_W = $clog2(`LED_HOLD);

	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			hold_cnt <= '0;
			led_o    <= 1'b0;
		end else begin
			if (act_i)
				hold_cnt <= CNT_W'(`LED_HOLD - 1);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			led_o <= act_i || (hold_cnt != '0);
		end
	end

endmodule

//--- src/audio_compressor.sv
// Stereo audio compressor
// two-stage pipeline: magnitude, then a two-segment gain curve with
// the sign restored; curve_sel_i picks the stronger second curve

`include "x68_glue_params.svh"

module audio_compressor (
	input  logic                  clk_sys,
	input  logic                  reset_delayed,
	input  logic                  curve_sel_i,
	input  x68_ctrl_pkg::sample_t in_l_i,
	input  x68_ctrl_pkg::sample_t in_r_i,
	output x68_ctrl_pkg::sample_t out_l_o,
	output x68_ctrl_pkg::sample_t out_r_o
);
	import x68_ctrl_pkg::*;

	localparam logic [15:0] A1 = 16'(`CMP_A1);
	localparam logic [15:0] F1 = 16'(`CMP_F1);
	localparam logic [15:0] X1 = 16'(`CMP_X1);
	localparam logic [15:0] B1 = 16'(`CMP_B1);
	localparam logic [15:0] A2 = 16'(`CMP_A2);
	localparam logic [15:0] F2 = 16'(`CMP_F2);
	localparam logic [15:0] X2 = 16'(`CMP_X2);
	localparam logic [15:0] B2 = 16'(`CMP_B2);

	// linear gain below the knee, flattened slope above it
	function automatic logic [15:0] shape(input logic [15:0] mag, input logic sel);
		logic [15:0] v1;
		logic [15:0] v2;
		v1 = (mag < X1) ? 16'(mag * A1) : 16'(((mag - X1) / F1) + B1);
		v2 = (mag < X2) ? 16'(mag * A2) : 16'(((mag - X2) / F2) + B2);
		return sel ? v2 : v1;
	endfunction

	sample_t     in_s [2];
	sample_t     out_s [2];
	logic [15:0] mag_q [2];
	logic [15:0] shaped [2];
	logic        neg_q [2];
	logic        sel_q;

	assign in_s[0] = in_l_i;
	assign in_s[1] = in_r_i;

	always_comb begin
		for (int c = 0; c < 2; c++)
			shaped[c] = shape(mag_q[c], sel_q);
	end

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			sel_q <= 1'b0;
			for (int c = 0; c < 2; c++) begin
				neg_q[c] <= 1'b0;
				mag_q[c] <= '0;
				out_s[c] <= '0;
			end
		end else begin
			// curve select travels with its sample
			sel_q <= curve_sel_i;
			for (int c = 0; c < 2; c++) begin
				// stage 1
				neg_q[c] <= in_s[c][15];
				mag_q[c] <= in_s[c][15] ? (~in_s[c] + 16'd1) : in_s[c];
				// stage 2
				out_s[c] <= neg_q[c] ? (~shaped[c] + 16'd1) : shaped[c];
			end
		end
	end

	assign out_l_o = out_s[0];
	assign out_r_o = out_s[1];

endmodule

//--- src/loader_bridge.sv
// Loader write bridge
// turns download write strobes into a loader request that is held
// until the core acknowledges it; closes the loader after the download

module loader_bridge (
	input  logic                    clk_sys,
	input  logic                    reset_delayed,
	input  logic                    download_i,
	input  logic                    ioctl_wr_i,
	input  x68_media_pkg::ldr_addr_t ioctl_addr_i,
	input  x68_media_pkg::ldr_data_t ioctl_dout_i,
	input  logic                    ldr_ack_i,
	output x68_media_pkg::ldr_addr_t ldr_addr_o,
	output x68_media_pkg::ldr_data_t ldr_wdat_o,
	output logic                    ldr_aen_o,
	output logic                    ldr_wr_o,
	output logic                    ldr_done_o
);

	logic ack_q;
	logic download_q;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			ack_q      <= 1'b0;
			download_q <= 1'b0;
			ldr_wr_o   <= 1'b0;
			ldr_done_o <= 1'b0;
		end else begin
			ack_q      <= ldr_ack_i;
			download_q <= download_i;

			if (ldr_ack_i && !ack_q && ldr_wr_o)
				ldr_wr_o <= 1'b0;
			// a fresh strobe wins over the ack clear
			if (ioctl_wr_i && !ldr_done_o)
				ldr_wr_o <= 1'b1;

			if (download_q && !download_i)
				ldr_done_o <= 1'b1;
		end
	end

	// address and data of the pending write
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i && !ldr_done_o) begin
			ldr_addr_o <= ioctl_addr_i;
			ldr_wdat_o <= ioctl_dout_i;
		end
	end

	assign ldr_aen_o = download_i & ~ldr_done_o;

	a_no_req_after_done: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		ldr_done_o |=> !$rose(ldr_wr_o));

endmodule

//--- src/reset_sequencer.sv
// Core reset and media sequencer
// holds the core in reset until the first download and the first
// menu reset release, restarts it after a hard disk mount, and
// stretches mount and eject events into windows for the floppy logic

`include "x68_glue_params.svh"

module reset_sequencer (
	input  logic                     clk_sys,
	input  logic                     reset_delayed,
	input  logic                     status_rst_i,
	input  logic                     button_rst_i,
	input  logic                     pll_locked_i,
	input  x68_media_pkg::drive_vec_t img_mounted_i,
	input  x68_media_pkg::fdd_vec_t   fd_eject_i,
	input  logic                     download_i,
	output x68_media_pkg::drive_vec_t mounted_d_o,
	output x68_media_pkg::fdd_vec_t   eject_d_o,
	output logic                     core_rstn_o
);
	import x68_media_pkg::*;

	localparam int MOUNT_W = $clog2(`MOUNT_HOLD + 1);
	localparam int EJECT_W = $clog2(`EJECT_HOLD + 1);
	localparam int HOLD_W  = $clog2(`HDD_RESET_HOLD + 1);
	// first quarter after a mount counts as an eject
	localparam logic [MOUNT_W-1:0] MOUNT_LATE = MOUNT_W'((`MOUNT_HOLD * 3) / 4);

	logic [MOUNT_W-1:0] mount_cnt [4];
	logic [EJECT_W-1:0] eject_cnt [2];
	logic [HOLD_W-1:0]  hdd_hold;
	logic               hdd_mnt_q;
	logic               download_q;
	logic               status_rst_q;
	logic               dl_seen;
	logic               rst_released;
	fdd_vec_t           eject_win;
	drive_vec_t         mounted_now;

	always_comb begin
		for (int i = 0; i < 2; i++)
			eject_win[i] = (eject_cnt[i] != '0) || (mount_cnt[i] > MOUNT_LATE);
		for (int s = 0; s < 4; s++)
			mounted_now[s] = (mount_cnt[s] != '0);
		// a floppy is not seen as mounted while its drive is ejecting
		mounted_now[1:0] = mounted_now[1:0] & ~eject_win;
	end

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			for (int s = 0; s < 4; s++)
				mount_cnt[s] <= '0;
			for (int i = 0; i < 2; i++)
				eject_cnt[i] <= '0;
			hdd_hold     <= '0;
			hdd_mnt_q    <= 1'b0;
			download_q   <= 1'b0;
			status_rst_q <= 1'b0;
			dl_seen      <= 1'b0;
			rst_released <= 1'b0;
			mounted_d_o  <= '0;
			eject_d_o    <= '0;
			core_rstn_o  <= 1'b0;
		end else begin
			hdd_mnt_q    <= img_mounted_i[SLOT_HDD];
			download_q   <= download_i;
			status_rst_q <= status_rst_i;

			// one-time release conditions
			if (download_i && !download_q)
				dl_seen <= 1'b1;
			if (status_rst_q && !status_rst_i)
				rst_released <= 1'b1;

			for (int s = 0; s < 4; s++) begin
				if (img_mounted_i[s])
					mount_cnt[s] <= MOUNT_W'(`MOUNT_HOLD);
				else if (mount_cnt[s] != '0)
					mount_cnt[s] <= mount_cnt[s] - 1'b1;
			end

			for (int i = 0; i < 2; i++) begin
				if (fd_eject_i[i])
					eject_cnt[i] <= EJECT_W'(`EJECT_HOLD);
				else if (eject_cnt[i] != '0)
					eject_cnt[i] <= eject_cnt[i] - 1'b1;
			end

			// new hard disk image restarts the machine
			if (img_mounted_i[SLOT_HDD] && !hdd_mnt_q)
				hdd_hold <= HOLD_W'(`HDD_RESET_HOLD);
			else if (hdd_hold != '0)
				hdd_hold <= hdd_hold - 1'b1;

			mounted_d_o <= mounted_now;
			eject_d_o   <= eject_win;
			core_rstn_o <= dl_seen && rst_released && !button_rst_i && pll_locked_i
				&& (hdd_hold == '0);
		end
	end

	a_hdd_hold: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		(hdd_hold != '0) |=> !core_rstn_o);

endmodule

//--- src/clk_enable_gen.sv
// Clock enable generator
// free-running dividers on clk_sys give the system, cpu phase,
// sound and fm enables; turbo doubles the cpu phase rate

`include "x68_glue_params.svh"

module clk_enable_gen (
	input  logic  clk_sys,
	input  logic  reset_delayed,
	input  logic  turbo_i,
	input  logic  clock_mode_i,
	clk_en_if.gen ce
);
	import x68_ctrl_pkg::*;

	localparam int SND_W  = $clog2(`SND_DIV);
	localparam int SND2_W = $clog2(`SND2_DIV);
	localparam int OPM_W  = $clog2(`OPM_DIV);

	logic [1:0]        div_sys;
	logic [SND_W-1:0]  div_snd;
	logic [SND2_W-1:0] div_snd2;
	logic [OPM_W-1:0]  div_opm;
	logic              snd_wrap;
	logic              snd2_wrap;
	logic              opm_wrap;
	logic              turbo_q;
	logic              sys_ce_q;
	logic              mpu_cep_q;
	logic              mpu_cen_q;
	logic              snd_ce_q;
	opm_ce_t           opm_ce_q;

	assign snd_wrap  = (div_snd == SND_W'(`SND_DIV - 1));
	assign snd2_wrap = (div_snd2 == SND2_W'(`SND2_DIV - 1));
	assign opm_wrap  = (div_opm == OPM_W'(`OPM_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			div_sys   <= '0;
			div_snd   <= '0;
			div_snd2  <= '0;
			div_opm   <= '0;
			turbo_q   <= 1'b0;
			sys_ce_q  <= 1'b0;
			mpu_cep_q <= 1'b0;
			mpu_cen_q <= 1'b0;
			snd_ce_q  <= 1'b0;
			opm_ce_q  <= '0;
		end else begin
			div_sys  <= div_sys + 2'd1;
			div_snd  <= snd_wrap ? '0 : div_snd + 1'b1;
			div_snd2 <= snd2_wrap ? '0 : div_snd2 + 1'b1;
			div_opm  <= opm_wrap ? '0 : div_opm + 1'b1;

			// speed only changes at the end of a bus cycle
			if (&div_sys)
				turbo_q <= turbo_i;

			sys_ce_q  <= &div_sys;
			mpu_cep_q <= turbo_q ? div_sys[0] : (div_sys == 2'd3);
			mpu_cen_q <= turbo_q ? ~div_sys[0] : (div_sys == 2'd1);

			snd_ce_q <= clock_mode_i ? snd2_wrap : snd_wrap;
			opm_ce_q <= {opm_wrap, snd2_wrap};
		end
	end

	assign ce.sys_ce  = sys_ce_q;
	assign ce.mpu_cep = mpu_cep_q;
	assign ce.mpu_cen = mpu_cen_q;
	assign ce.snd_ce  = snd_ce_q;
	assign ce.opm_ce  = opm_ce_q;

	// the two cpu phases must stay apart, also across a turbo switch
	a_phase_excl: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		!(ce.mpu_cep && ce.mpu_cen));

endmodule

//--- common/clk_en_if.sv
// Clock enable bundle
// single-cycle enables from the divider to the core side

interface clk_en_if;
	import x68_ctrl_pkg::*;

	logic    sys_ce;
	logic    mpu_cep;
	logic    mpu_cen;
	logic    snd_ce;
	opm_ce_t opm_ce;

	modport gen (output sys_ce, mpu_cep, mpu_cen, snd_ce, opm_ce);
	modport core (input sys_ce, mpu_cep, mpu_cen, snd_ce, opm_ce);

endinterface

//--- common/x68_media_pkg.sv
// X68000 media-side types
// image slot vectors and loader bus widths

package x68_media_pkg;

	// one bit per image slot: fdd0, fdd1, hdd, sram
	typedef logic [3:0] drive_vec_t;

	// one bit per floppy drive
	typedef logic [1:0] fdd_vec_t;

	// slot index of the hard disk image
	localparam int SLOT_HDD = 2;

	// loader address and write data
	typedef logic [19:0] ldr_addr_t;
	typedef logic [7:0]  ldr_data_t;

endpackage

//--- common/x68_ctrl_pkg.sv
// X68000 control-side types
// status word as sent by the menu system, enable vectors and audio samples

package x68_ctrl_pkg;

	// field view of the status word, bit 0 at the bottom
	typedef struct packed {
		logic [63:22] rsvd_hi;
		logic         curve_sel;
		logic [20:15] rsvd_mid;
		logic         sram_store;
		logic         sram_load;
		logic [1:0]   fd_eject;
		logic [1:0]   fd_sync;
		logic         power;
		logic         nmi;
		logic [6:5]   rsvd_lo;
		logic         turbo;
		logic         vid_60hz;
		logic [2:1]   rsvd_base;
		logic         reset;
	} status_fields_t;

	// one word, read either raw or by field
	typedef union packed {
		logic [63:0]    raw;
		status_fields_t f;
	} status_word_t;

	// bit 0 at the fm rate, bit 1 at half of it
	typedef logic [1:0] opm_ce_t;

	// 16-bit two's complement audio sample
	typedef logic [15:0] sample_t;

endpackage

//--- common/x68_glue_params.svh
// X68000 glue parameters
// hold lengths, divider terminal counts and compressor curve constants
// shared by the clocking, reset, audio and LED blocks

`ifndef X68_GLUE_PARAMS_SVH
`define X68_GLUE_PARAMS_SVH

// hold counter lengths in clk_sys cycles
`define MOUNT_HOLD      4096
`define EJECT_HOLD      1024
`define HDD_RESET_HOLD  2048
`define LED_HOLD        512

// enable divider periods
`define SND_DIV         5
`define SND2_DIV        10
`define OPM_DIV         20

// curve 1, gentle
`define CMP_A1          2
`define CMP_F1          4
`define CMP_X1          14044
`define CMP_B1          (`CMP_X1 * `CMP_A1)

// curve 2, strong
`define CMP_A2          4
`define CMP_F2          8
`define CMP_X2          7400
`define CMP_B2          (`CMP_X2 * `CMP_A2)

`endif
